//--- compile.f
verilog/icache_pkg.sv
verilog/icache_slice.sv
verilog/icache_refill_ctrl.sv
verilog/icache_read_sel.sv
verilog/icache_top.sv
dv/icache_asserts.sv
dv/icache_tb.sv

//--- Bender.yml
package:
  name: icache

sources:
  - verilog/icache_pkg.sv
  - verilog/icache_slice.sv
  - verilog/icache_refill_ctrl.sv
  - verilog/icache_read_sel.sv
  - verilog/icache_top.sv
  - target: simulation
    files:
      - dv/icache_asserts.sv
      - dv/icache_tb.sv

//--- dv/icache_tb.sv
/*
 * Instruction cache testbench
 * Random L2 model with credit returns, directed and random
 * fetches checked against a residency model of the ways
 */

`timescale 1ns/100ps

module icache_tb
	import icache_pkg::*;
;

	localparam int CLK_PERIOD = 100;
	localparam int SEED = 32'h4c35_497a;
	localparam int N_DIRECTED = 13;
	localparam int N_RANDOM = 300;
	// Worst refill plus slack, per fetch
	localparam int FETCH_LIMIT = WORDS_PER_SLICE * 5 + 10;
	localparam int WATCHDOG_CYCLES = (N_DIRECTED + N_RANDOM) * FETCH_LIMIT;

	logic  clk = 1'b0;
	logic  rst_n;
	addr_t i_pc;
	logic  i_l2_rvalid;
	word_t i_l2_rdata;
	word_t o_code;
	logic  o_code_valid;
	logic  o_miss;
	logic  o_l2_req;
	addr_t o_l2_addr;

	// L2 backing store for the 1 KB window
	word_t l2_mem [256];
	// Reads in flight, oldest first
	addr_t l2_addr_q [$];
	int    l2_due_q [$];
	int    l2_cycle = 0;
	int    last_due = 0;
	int    outstanding = 0;
	int    fetch_reqs = 0;
	addr_t exp_req_addr = '0;

	// Residency model of the ways
	addr_t model_base [NUM_WAYS];
	bit    model_valid [NUM_WAYS];
	int    model_victim = 0;
	// Recently fetched blocks for biased stimulus
	addr_t recent [$];

	always #(CLK_PERIOD / 2) clk = ~clk;

	icache_top icache_top_inst
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.i_pc         (i_pc),
		.i_l2_rvalid  (i_l2_rvalid),
		.i_l2_rdata   (i_l2_rdata),
		.o_code       (o_code),
		.o_code_valid (o_code_valid),
		.o_miss       (o_miss),
		.o_l2_req     (o_l2_req),
		.o_l2_addr    (o_l2_addr)
	);

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act)
		begin
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
			$display("Something failed");
			$fatal(1, "Mismatch in %s", name);
		end
	endtask

	// L2 answers in order after 0 to 3 idle cycles
	always @(negedge clk)
	begin
		int    due;
		addr_t a;
		l2_cycle++;
		i_l2_rvalid = 1'b0;
		if (l2_due_q.size() != 0 && l2_due_q[0] <= l2_cycle)
		begin
			a = l2_addr_q.pop_front();
			void'(l2_due_q.pop_front());
			i_l2_rvalid = 1'b1;
			i_l2_rdata = l2_mem[a[9:2]];
			outstanding--;
		end
		// Request seen here is taken at the next rising edge
		if (rst_n && o_l2_req)
		begin
			check("l2 request address", exp_req_addr, o_l2_addr);
			exp_req_addr += addr_t'(WORD_BYTES);
			fetch_reqs++;
			due = l2_cycle + 1 + int'($urandom_range(3));
			if (due <= last_due)
				due = last_due + 1;
			last_due = due;
			l2_addr_q.push_back(o_l2_addr);
			l2_due_q.push_back(due);
			outstanding++;
		end
		check("credit upper limit", 1, outstanding <= L2_CREDITS);
	end

	function automatic int resident_way(input addr_t base);
		for (int w = 0; w < NUM_WAYS; w++)
			if (model_valid[w] && model_base[w] == base)
				return w;
		return -1;
	endfunction

	// Caller sits on a falling edge
	task automatic fetch(input string name, input addr_t pc, output bit was_miss);
		addr_t base;
		bit    exp_hit;
		int    cycles;
		base = {pc[31:SLICE_SHIFT], {SLICE_SHIFT{1'b0}}};
		exp_hit = (resident_way(base) >= 0);
		exp_req_addr = base;
		fetch_reqs = 0;
		i_pc = pc;
		@(negedge clk);
		cycles = 1;
		check({name, " miss flag"}, !exp_hit, o_miss);
		while (!o_code_valid)
		begin
			if (cycles > FETCH_LIMIT)
			begin
				$display("Something failed");
				$fatal(1, "Fetch %s at %h returned no code in time", name, pc);
			end
			@(negedge clk);
			cycles++;
		end
		was_miss = (fetch_reqs != 0);
		check({name, " l2 traffic"}, !exp_hit, was_miss);
		if (exp_hit)
			check({name, " hit latency"}, 1, cycles);
		else
			check({name, " request count"}, WORDS_PER_SLICE, fetch_reqs);
		check({name, " code"}, l2_mem[pc[9:2]], o_code);
		// Refill lands in the round-robin victim
		if (!exp_hit)
		begin
			model_base[model_victim] = base;
			model_valid[model_victim] = 1'b1;
			model_victim = (model_victim + 1) % NUM_WAYS;
		end
	endtask

	task automatic directed(input string name, input addr_t pc, input bit exp_miss);
		bit m;
		fetch(name, pc, m);
		check({name, " outcome"}, exp_miss, m);
	endtask

	// Mostly revisit recent blocks, sometimes any block in the window
	task automatic choose_fetch_addr(output addr_t pc);
		addr_t base;
		if (recent.size() != 0 && $urandom_range(99) < 70)
			base = recent[$urandom_range(recent.size() - 1)];
		else
			base = addr_t'($urandom_range(15)) << SLICE_SHIFT;
		pc = base + (addr_t'($urandom_range(WORDS_PER_SLICE - 1)) << 2);
	endtask

	initial
	begin
		addr_t pc;
		bit    m;
		void'($urandom(SEED));
		for (int i = 0; i < 256; i++)
			l2_mem[i] = $urandom();
		for (int w = 0; w < NUM_WAYS; w++)
			model_valid[w] = 1'b0;
		rst_n = 1'b0;
		i_pc = '0;
		i_l2_rvalid = 1'b0;
		i_l2_rdata = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		check("reset code valid", 0, o_code_valid);
		rst_n = 1'b1;
		// Cold miss then hits in the same block
		directed("cold miss", 32'h010, 1'b1);
		directed("hit first word", 32'h000, 1'b0);
		directed("hit last word", 32'h03c, 1'b0);
		directed("hit middle word", 32'h024, 1'b0);
		// Fifth block evicts the first
		directed("fill block 1", 32'h048, 1'b1);
		directed("fill block 2", 32'h0b0, 1'b1);
		directed("fill block 3", 32'h0c4, 1'b1);
		directed("fill block 4", 32'h13c, 1'b1);
		directed("keep block 2", 32'h080, 1'b0);
		directed("keep block 3", 32'h0c0, 1'b0);
		directed("keep block 4", 32'h100, 1'b0);
		directed("evicted block 0", 32'h004, 1'b1);
		directed("evicted block 1", 32'h07c, 1'b1);
		for (int n = 0; n < N_RANDOM; n++)
		begin
			choose_fetch_addr(pc);
			fetch("random", pc, m);
			recent.push_back({pc[31:SLICE_SHIFT], {SLICE_SHIFT{1'b0}}});
			if (recent.size() > 6)
				void'(recent.pop_front());
		end
		if (icache_top_inst.icache_refill_ctrl_inst.refill_asserts_inst.err_cnt != 0)
		begin
			$display("Something failed");
			$fatal(1, "Refill controller assertions reported errors");
		end
		else
		begin
			$display("Everything OK");
			$finish;
		end
	end

	// Ends a stuck run
	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Something failed");
		$fatal(1, "Watchdog expired before all fetches completed");
	end

endmodule

//--- dv/icache_asserts.sv
/*
 * Refill controller assertions
 * Credit budget, request gating and fill strobe rules
 */

`timescale 1ns/100ps

module icache_refill_asserts
	import icache_pkg::*;
(
	input logic                clk,
	input logic                rst_n,
	input refill_state_e       i_state,
	input logic                i_l2_req,
	input logic                i_l2_rvalid,
	input logic [NUM_WAYS-1:0] i_fill_we
);

	// Reads in flight at L2
	int outstanding;
	// Failed assertion count
	int err_cnt = 0;

	always_ff @(posedge clk, negedge rst_n)
	begin
		if (!rst_n)
			outstanding <= 0;
		else
			outstanding <= outstanding + int'(i_l2_req) - int'(i_l2_rvalid);
	end

	a_credit_budget: assert property (@(posedge clk) disable iff (!rst_n)
		outstanding <= L2_CREDITS)
	else
	begin
		err_cnt++;
		$error("More L2 reads in flight than credits allow");
	end

	a_idle_no_req: assert property (@(posedge clk) disable iff (!rst_n)
		(i_state == IDLE) |-> !i_l2_req)
	else
	begin
		err_cnt++;
		$error("L2 request raised while refill FSM is idle");
	end

	a_fill_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(i_fill_we))
	else
	begin
		err_cnt++;
		$error("More than one way written by a refill word");
	end

	a_reset_no_req: assert property (@(posedge clk) !rst_n |-> !i_l2_req)
	else
	begin
		err_cnt++;
		$error("L2 request raised during reset");
	end

endmodule

bind icache_refill_ctrl icache_refill_asserts refill_asserts_inst
(
	.clk         (clk),
	.rst_n       (rst_n),
	.i_state     (state),
	.i_l2_req    (o_l2_req),
	.i_l2_rvalid (i_l2_rvalid),
	.i_fill_we   (o_fill_we)
);

//--- verilog/icache_top.sv
/*
 * Tag-free L1 instruction cache
 * Refill controller, generated ways and read selector
 * between the fetch port and a credit-based L2 read port
 */

`timescale 1ns/100ps

module icache_top
	import icache_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  addr_t i_pc,
	input  logic  i_l2_rvalid,
	input  word_t i_l2_rdata,
	output word_t o_code,
	output logic  o_code_valid,
	output logic  o_miss,
	output logic  o_l2_req,
	output addr_t o_l2_addr
);

	// Way status
	logic [NUM_WAYS-1:0]   way_hit;
	word_t                 way_word [NUM_WAYS];

	// Fill and commit controls shared by the ways
	logic [NUM_WAYS-1:0]   fill_we;
	logic [WORD_IDX_W-1:0] fill_idx;
	word_t                 fill_data;
	logic [NUM_WAYS-1:0]   commit;
	addr_t                 new_base;

	icache_refill_ctrl icache_refill_ctrl_inst
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.i_pc        (i_pc),
		.i_hit       (way_hit),
		.i_l2_rvalid (i_l2_rvalid),
		.i_l2_rdata  (i_l2_rdata),
		.o_miss      (o_miss),
		.o_l2_req    (o_l2_req),
		.o_l2_addr   (o_l2_addr),
		.o_fill_we   (fill_we),
		.o_fill_idx  (fill_idx),
		.o_fill_data (fill_data),
		.o_commit    (commit),
		.o_new_base  (new_base)
	);

	// One slice per way
	for (genvar w = 0; w < NUM_WAYS; w++)
	begin : g_way
		icache_slice icache_slice_inst
		(
			.clk         (clk),
			.rst_n       (rst_n),
			.i_pc        (i_pc),
			.i_fill_we   (fill_we[w]),
			.i_fill_idx  (fill_idx),
			.i_fill_data (fill_data),
			.i_commit    (commit[w]),
			.i_new_base  (new_base),
			.o_hit       (way_hit[w]),
			.o_word      (way_word[w])
		);
	end

	icache_read_sel icache_read_sel_inst
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.i_hit        (way_hit),
		.i_word       (way_word),
		.o_code       (o_code),
		.o_code_valid (o_code_valid)
	);

endmodule

//--- verilog/icache_read_sel.sv
/*
 * Instruction cache read selector
 * Registers the way hit vector and returns the word of
 * the way that hit in the previous cycle
 */

`timescale 1ns/100ps

module icache_read_sel
	import icache_pkg::*;
(
	input  logic                clk,
	input  logic                rst_n,
	input  logic [NUM_WAYS-1:0] i_hit,
	input  word_t               i_word [NUM_WAYS],
	output word_t               o_code,
	output logic                o_code_valid
);

	// Hit vector aligned with the registered way words
	logic [NUM_WAYS-1:0] hit_q;

	always_ff @(posedge clk, negedge rst_n)
	begin
		if (!rst_n)
			hit_q <= '0;
		else
			hit_q <= i_hit;
	end

	assign o_code_valid = |hit_q;

	// Ranges never overlap so an AND-OR mux is enough
	always_comb
	begin
		o_code = '0;
		for (int w = 0; w < NUM_WAYS; w++)
			o_code = o_code | (i_word[w] & {$bits(word_t){hit_q[w]}});
	end

endmodule

//--- verilog/icache_refill_ctrl.sv
/*
 * Instruction cache refill controller
 * Detects misses, reads the missing block from L2 under credit
 * flow control and steers it into a round-robin victim way
 */

`timescale 1ns/100ps

module icache_refill_ctrl
	import icache_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  addr_t                 i_pc,
	input  logic [NUM_WAYS-1:0]   i_hit,
	input  logic                  i_l2_rvalid,
	input  word_t                 i_l2_rdata,
	output logic                  o_miss,
	output logic                  o_l2_req,
	output addr_t                 o_l2_addr,
	output logic [NUM_WAYS-1:0]   o_fill_we,
	output logic [WORD_IDX_W-1:0] o_fill_idx,
	output word_t                 o_fill_data,
	output logic [NUM_WAYS-1:0]   o_commit,
	output addr_t                 o_new_base
);

	refill_state_e state, state_nxt;

	// Block being refilled
	addr_t block_base;

	// Requests issued, one extra bit to count all 16
	logic [WORD_IDX_W:0]   req_cnt;
	// Words returned so far, doubles as fill index
	logic [WORD_IDX_W-1:0] ret_cnt;
	logic [CREDIT_W-1:0]   credit_cnt;
	logic [WAY_IDX_W-1:0]  victim_ptr;
	logic [NUM_WAYS-1:0]   victim_oh;
	logic                  pc_miss;
	logic                  last_ret;

	assign pc_miss   = ~|i_hit;
	assign last_ret  = i_l2_rvalid && (ret_cnt == WORD_IDX_W'(WORDS_PER_SLICE - 1));
	assign victim_oh = NUM_WAYS'(1) << victim_ptr;

	always_comb
	begin
		state_nxt = state;
		case (state)
			IDLE:
				if (pc_miss)
					state_nxt = REQUEST;
			REQUEST:
				// Leave once the last word is back
				if (last_ret)
					state_nxt = COMMIT;
			COMMIT:
				state_nxt = IDLE;
			default:
				state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk, negedge rst_n)
	begin
		if (!rst_n)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	// Latch aligned base at miss time
	always_ff @(posedge clk)
	begin
		if (state == IDLE && pc_miss)
			block_base <= {i_pc[$bits(addr_t)-1:SLICE_SHIFT], {SLICE_SHIFT{1'b0}}};
	end

	// Request and return counters restart on every miss
	always_ff @(posedge clk, negedge rst_n)
	begin
		if (!rst_n)
		begin
			req_cnt <= '0;
			ret_cnt <= '0;
		end
		else if (state == IDLE)
		begin
			req_cnt <= '0;
			ret_cnt <= '0;
		end
		else
		begin
			if (o_l2_req)
				req_cnt <= req_cnt + 1'b1;
			if (i_l2_rvalid)
				ret_cnt <= ret_cnt + 1'b1;
		end
	end

	// One credit per request out, one back per rvalid
	always_ff @(posedge clk, negedge rst_n)
	begin
		if (!rst_n)
			credit_cnt <= CREDIT_W'(L2_CREDITS);
		else if (o_l2_req && !i_l2_rvalid)
			credit_cnt <= credit_cnt - 1'b1;
		else if (!o_l2_req && i_l2_rvalid)
			credit_cnt <= credit_cnt + 1'b1;
	end

	// Round-robin victim, moves on after each commit
	always_ff @(posedge clk, negedge rst_n)
	begin
		if (!rst_n)
			victim_ptr <= '0;
		else if (state == COMMIT)
			victim_ptr <= victim_ptr + 1'b1;
	end

	assign o_miss = pc_miss || (state != IDLE);

	// Issue while words remain and credit is left
	assign o_l2_req = (state == REQUEST) &&
		(req_cnt < (WORD_IDX_W + 1)'(WORDS_PER_SLICE)) && (credit_cnt != '0);
	assign o_l2_addr = block_base + (addr_t'(req_cnt) << $clog2(WORD_BYTES));

	// Returned words go straight to the victim
	assign o_fill_we   = (state == REQUEST && i_l2_rvalid) ? victim_oh : '0;
	assign o_fill_idx  = ret_cnt;
	assign o_fill_data = i_l2_rdata;

	assign o_commit   = (state == COMMIT) ? victim_oh : '0;
	assign o_new_base = block_base;

endmodule

//--- verilog/icache_slice.sv
/*
 * Instruction cache way
 * Base/bound range check for hits, word storage filled
 * from L2 and a registered read port indexed by the fetch PC
 */

`timescale 1ns/100ps

module icache_slice
	import icache_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  addr_t                 i_pc,
	input  logic                  i_fill_we,
	input  logic [WORD_IDX_W-1:0] i_fill_idx,
	input  word_t                 i_fill_data,
	input  logic                  i_commit,
	input  addr_t                 i_new_base,
	output logic                  o_hit,
	output word_t                 o_word
);

	// Range of addresses this way covers
	addr_t base_q;
	addr_t bound_q;

	// Block storage
	word_t mem [WORDS_PER_SLICE];

	// All ones after reset so nothing can hit
	always_ff @(posedge clk, negedge rst_n)
	begin
		if (!rst_n)
		begin
			base_q  <= '1;
			bound_q <= '1;
		end
		else if (i_commit)
		begin
			base_q  <= i_new_base;
			// Bound sits one block above base
			bound_q <= i_new_base + addr_t'(SLICE_BYTES);
		end
	end

	// Hit when PC inside [base, bound)
	assign o_hit = (i_pc >= base_q) && (i_pc < bound_q);

	// Refill write port
	always_ff @(posedge clk)
	begin
		if (i_fill_we)
			mem[i_fill_idx] <= i_fill_data;
	end

	// Word index taken just above the byte offset
	always_ff @(posedge clk)
	begin
		o_word <= mem[i_pc[$clog2(WORD_BYTES) +: WORD_IDX_W]];
	end

endmodule

//--- verilog/icache_pkg.sv
/*
 * Instruction cache shared definitions
 * Geometry of the tag-free ways, the L2 credit budget,
 * the data and address types and the refill FSM states
 */

package icache_pkg;

	// Way count and way index width
	localparam int NUM_WAYS = 4;
	localparam int WAY_IDX_W = 2;

	// One way holds one aligned block
	localparam int WORDS_PER_SLICE = 16;
	localparam int WORD_BYTES = 4;
	localparam int SLICE_BYTES = WORDS_PER_SLICE * WORD_BYTES;

	// Low address bits cleared to form a block base
	localparam int SLICE_SHIFT = 6;
	localparam int WORD_IDX_W = 4;

	// Outstanding L2 reads allowed at once
	localparam int L2_CREDITS = 2;
	localparam int CREDIT_W = $clog2(L2_CREDITS + 1);

	// 32-bit instruction word
	typedef logic [31:0] word_t;

	// 32-bit byte address
	typedef logic [31:0] addr_t;

	// Refill FSM
	typedef enum logic [1:0]
	{
		IDLE,
		REQUEST,
		COMMIT
	} refill_state_e;

endpackage
